/* dv/tb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_top;

	localparam int cache_index_bits = 4;
	localparam int cache_lines      = 1 << cache_index_bits;
	localparam int wait_limit       = 200;
	localparam int transactions     = 400;

	logic           clock;
	logic           reset;
	bus_pkg::addr_t ifu_araddr;
	logic           ifu_arvalid;
	logic           ifu_arready;
	bus_pkg::data_t ifu_rdata;
	bus_pkg::resp_t ifu_rresp;
	logic           ifu_rvalid;
	logic           ifu_rready;
	bus_pkg::addr_t lsu_araddr;
	logic           lsu_arvalid;
	logic           lsu_arready;
	bus_pkg::data_t lsu_rdata;
	bus_pkg::resp_t lsu_rresp;
	logic           lsu_rvalid;
	logic           lsu_rready;
	bus_pkg::addr_t mem_araddr;
	logic           mem_arvalid;
	logic           mem_arready;
	bus_pkg::data_t mem_rdata;
	bus_pkg::resp_t mem_rresp;
	logic           mem_rvalid;
	logic           mem_rready;

	logic [31:0]    lfsr;
	logic [31:0]    cycles; // edges out of reset, tracks the timer count.
	int             mem_reads;
	logic           mem_busy;
	bus_pkg::addr_t mem_addr;
	int             mem_delay;

	int             ifu_got;
	int             lsu_got;
	bus_pkg::data_t ifu_data;
	bus_pkg::resp_t ifu_resp;
	bus_pkg::data_t lsu_data;
	bus_pkg::resp_t lsu_resp;
	logic [31:0]    ifu_ar_cycle;
	logic [31:0]    lsu_ar_cycle;
	logic [31:0]    lsu_r_cycle;
	logic           ifu_hold;
	bus_pkg::data_t ifu_hold_data;
	bus_pkg::resp_t ifu_hold_resp;
	logic           lsu_hold;
	bus_pkg::data_t lsu_hold_data;
	bus_pkg::resp_t lsu_hold_resp;

	// reference icache, same index and tag split as a direct-mapped store.
	logic           model_valid [cache_lines];
	logic [31:0]    model_tag [cache_lines];

	fetch_load_top #(
		.cache_index_bits(cache_index_bits)
	) dut0 (.*);

	always #4 clock = ~clock;

	// --------------------------------------------------
	// random source and memory rules
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic bus_pkg::data_t mem_word(input bus_pkg::addr_t a);
		return a ^ 32'ha5a5_0000;
	endfunction

	function automatic bus_pkg::resp_t mem_resp(input bus_pkg::addr_t a);
		return (a[11:8] == 4'hf) ? bus_pkg::resp_slverr : bus_pkg::resp_okay;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// --------------------------------------------------
	// one clock: observe handshakes, then drive the next inputs
	task automatic step_cycle();
		logic [31:0] r;
		@(posedge clock);
		if (ifu_hold) begin
			check_value("ifu stalled data", ifu_hold_data, ifu_rdata);
			check_value("ifu stalled valid and resp", {29'd0, 1'b1, ifu_hold_resp},
			            {29'd0, ifu_rvalid, ifu_rresp});
		end
		if (lsu_hold) begin
			check_value("lsu stalled data", lsu_hold_data, lsu_rdata);
			check_value("lsu stalled valid and resp", {29'd0, 1'b1, lsu_hold_resp},
			            {29'd0, lsu_rvalid, lsu_rresp});
		end
		ifu_hold      = ifu_rvalid & ~ifu_rready;
		ifu_hold_data = ifu_rdata;
		ifu_hold_resp = ifu_rresp;
		lsu_hold      = lsu_rvalid & ~lsu_rready;
		lsu_hold_data = lsu_rdata;
		lsu_hold_resp = lsu_rresp;

		if (ifu_arvalid && ifu_arready) begin
			ifu_arvalid  <= 1'b0;
			ifu_ar_cycle = cycles;
		end
		if (lsu_arvalid && lsu_arready) begin
			lsu_arvalid  <= 1'b0;
			lsu_ar_cycle = cycles;
		end
		if (ifu_rvalid && ifu_rready) begin
			ifu_got++;
			ifu_data = ifu_rdata;
			ifu_resp = ifu_rresp;
		end
		if (lsu_rvalid && lsu_rready) begin
			lsu_got++;
			lsu_data    = lsu_rdata;
			lsu_resp    = lsu_rresp;
			lsu_r_cycle = cycles;
		end

		// memory model, one read outstanding.
		if (mem_arvalid && mem_arready) begin
			mem_reads++;
			mem_busy = 1'b1;
			mem_addr = mem_araddr;
			take_bits(2, r);
			mem_delay = int'(r[1:0]);
		end
		if (mem_rvalid && mem_rready) begin
			mem_rvalid <= 1'b0;
			mem_busy   = 1'b0;
		end else if (mem_busy && !mem_rvalid) begin
			if (mem_delay == 0) begin
				mem_rvalid <= 1'b1;
				mem_rdata  <= mem_word(mem_addr);
				mem_rresp  <= mem_resp(mem_addr);
			end else begin
				mem_delay--;
			end
		end
		take_bits(1, r);
		mem_arready <= ~mem_busy & r[0];
		take_bits(1, r);
		ifu_rready <= r[0];
		take_bits(1, r);
		lsu_rready <= r[0];
		cycles++;
	endtask

	// --------------------------------------------------
	// issue one fetch, one load or both, then check the replies
	task automatic run_transaction(input logic do_fetch, input logic do_load,
	                               input bus_pkg::addr_t f_addr,
	                               input bus_pkg::addr_t l_addr);
		int          idx;
		logic [31:0] tag;
		logic        hit;
		logic        to_timer;
		int          reads_before;
		int          expect_reads;
		int          waited;

		idx          = int'((f_addr >> 2) & (cache_lines - 1));
		tag          = f_addr >> (cache_index_bits + 2);
		hit          = do_fetch && model_valid[idx] && (model_tag[idx] == tag);
		to_timer     = (l_addr >= bus_pkg::timer_base) && (l_addr <= bus_pkg::timer_last);
		expect_reads = 0;
		if (do_fetch && !hit)
			expect_reads++;
		if (do_load && !to_timer)
			expect_reads++;
		reads_before = mem_reads;
		ifu_got      = 0;
		lsu_got      = 0;
		if (do_fetch) begin
			ifu_araddr  <= f_addr;
			ifu_arvalid <= 1'b1;
		end
		if (do_load) begin
			lsu_araddr  <= l_addr;
			lsu_arvalid <= 1'b1;
		end

		waited = 0;
		while (ifu_got < int'(do_fetch) || lsu_got < int'(do_load)) begin
			step_cycle();
			waited++;
			if (waited > wait_limit) begin
				$display("timeout: a request got no reply within %0d cycles", wait_limit);
				$display("Done: errors found");
				$fatal(1);
			end
		end
		repeat (3) step_cycle(); // room for a stray second reply.

		check_value("memory read count", expect_reads, mem_reads - reads_before);
		check_value("fetch reply count", int'(do_fetch), ifu_got);
		check_value("load reply count", int'(do_load), lsu_got);
		if (do_fetch) begin
			check_value("fetch data", mem_word(f_addr), ifu_data);
			check_value("fetch resp", {30'd0, mem_resp(f_addr)}, {30'd0, ifu_resp});
			if (mem_resp(f_addr) == bus_pkg::resp_okay) begin
				model_valid[idx] = 1'b1;
				model_tag[idx]   = tag;
			end
		end
		if (do_load && !to_timer) begin
			check_value("load data", mem_word(l_addr), lsu_data);
			check_value("load resp", {30'd0, mem_resp(l_addr)}, {30'd0, lsu_resp});
		end else if (do_load && l_addr == bus_pkg::timer_base) begin
			check_value("timer resp", {30'd0, bus_pkg::resp_okay}, {30'd0, lsu_resp});
			check_value("timer at or after request", 32'd1,
			            {31'd0, lsu_data >= lsu_ar_cycle});
			check_value("timer at or before reply", 32'd1,
			            {31'd0, lsu_data <= lsu_r_cycle});
		end else if (do_load) begin
			check_value("timer hole data", 32'd0, lsu_data);
			check_value("timer hole resp", {30'd0, bus_pkg::resp_slverr}, {30'd0, lsu_resp});
		end
		if (do_fetch && do_load)
			check_value("fetch accepted first", 32'd1, {31'd0, ifu_ar_cycle < lsu_ar_cycle});
	endtask

	// --------------------------------------------------
	initial begin
		int             n;
		int             i;
		logic [31:0]    r;
		logic [31:0]    off;
		logic           do_f;
		logic           do_l;
		bus_pkg::addr_t f_addr;
		bus_pkg::addr_t l_addr;

		clock       = 1'b0;
		reset       = 1'b1;
		ifu_araddr  = '0;
		ifu_arvalid = 1'b0;
		ifu_rready  = 1'b0;
		lsu_araddr  = '0;
		lsu_arvalid = 1'b0;
		lsu_rready  = 1'b0;
		mem_arready = 1'b0;
		mem_rdata   = '0;
		mem_rresp   = '0;
		mem_rvalid  = 1'b0;
		lfsr        = 32'd84673;
		cycles      = '0;
		mem_reads   = 0;
		mem_busy    = 1'b0;
		mem_addr    = '0;
		mem_delay   = 0;
		ifu_got     = 0;
		lsu_got     = 0;
		ifu_hold    = 1'b0;
		lsu_hold    = 1'b0;
		for (i = 0; i < cache_lines; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i]   = '0;
		end

		repeat (8) @(posedge clock);
		check_value("valid and ready in reset", 32'd0,
		            {27'd0, ifu_rvalid, lsu_rvalid, mem_arvalid, ifu_arready, lsu_arready});
		reset <= 1'b0;

		for (n = 0; n < transactions; n++) begin
			take_bits(3, r);
			do_f = r[2:0] <= 3'd4;                      // 0 gives both at once.
			do_l = (r[2:0] == 3'd0) || (r[2:0] >= 3'd5);

			// few lines and four tags, so fetches repeat and collide.
			take_bits(3, r);
			take_bits(2, off);
			case (off[1:0])
				2'd0:    off = 32'h000;
				2'd1:    off = 32'h040;
				2'd2:    off = 32'h400;
				default: off = 32'hf00; // bits 11:8 all ones, memory error.
			endcase
			f_addr = 32'h0000_1000 + off + {27'd0, r[2:0], 2'b00};

			take_bits(2, r);
			if (r[1:0] == 2'd0) begin
				take_bits(1, r);
				if (r[0]) begin
					l_addr = bus_pkg::timer_base;
				end else begin
					take_bits(4, r);
					l_addr = bus_pkg::timer_base + 32'h100 + {26'd0, r[3:0], 2'b00};
				end
			end else begin
				take_bits(12, r);
				l_addr = 32'h0001_0000 + {18'd0, r[11:0], 2'b00};
			end
			run_transaction(do_f, do_l, f_addr, l_addr);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the fetch/load crossbar testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f sim.f \
	-o tb_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see $build_log"
	exit 1
fi

./obj_dir/tb_sim > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
	echo "simulation ended with an error status, see $sim_log"
	exit 1
fi

if grep -q "^Done: no errors$" "$sim_log"; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see $sim_log"
exit 1

/* sim.f */
src/bus_pkg.sv
src/axil_read_if.sv
src/axil_write_if.sv
src/fetch_cache.sv
src/timer_clint.sv
src/bus_xbar.sv
src/fetch_load_top.sv
dv/tb_top.sv

/* src/axil_read_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface axil_read_if;

	bus_pkg::addr_t araddr;
	logic           arvalid;
	logic           arready;
	bus_pkg::data_t rdata;
	bus_pkg::resp_t rresp;
	logic           rvalid;
	logic           rready;

	modport requester (
		output araddr, arvalid, rready,
		input  arready, rdata, rresp, rvalid
	);

	modport responder (
		input  araddr, arvalid, rready,
		output arready, rdata, rresp, rvalid
	);

endinterface

`default_nettype wire

/* src/axil_write_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface axil_write_if;

	bus_pkg::addr_t awaddr;
	logic           awvalid;
	logic           awready;
	bus_pkg::data_t wdata;
	logic           wvalid;
	logic           wready;
	bus_pkg::resp_t bresp;
	logic           bvalid;
	logic           bready;

	modport requester (
		output awaddr, awvalid, wdata, wvalid, bready,
		input  awready, wready, bresp, bvalid
	);

	modport responder (
		input  awaddr, awvalid, wdata, wvalid, bready,
		output awready, wready, bresp, bvalid
	);

endinterface

`default_nettype wire

/* src/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t resp_okay   = 2'd0;
	localparam resp_t resp_slverr = 2'd2;
	localparam resp_t resp_decerr = 2'd3; // also the icache miss code.

	// machine timer window, decoded on load addresses.
	localparam addr_t timer_base = 32'h0200_0000;
	localparam addr_t timer_last = 32'h0200_ffff;

	typedef enum logic [2:0] {
		idle,
		fetch_lookup,
		fetch_memory,
		fetch_fill,
		fetch_reply,
		load_read,
		load_reply
	} xbar_state_e;

endpackage

`default_nettype wire

/* src/bus_xbar.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_xbar (
	input  wire                 clock,
	input  wire                 reset,

	input  wire bus_pkg::addr_t ifu_araddr,
	input  wire                 ifu_arvalid,
	output logic                ifu_arready,
	output bus_pkg::data_t      ifu_rdata,
	output bus_pkg::resp_t      ifu_rresp,
	output logic                ifu_rvalid,
	input  wire                 ifu_rready,

	input  wire bus_pkg::addr_t lsu_araddr,
	input  wire                 lsu_arvalid,
	output logic                lsu_arready,
	output bus_pkg::data_t      lsu_rdata,
	output bus_pkg::resp_t      lsu_rresp,
	output logic                lsu_rvalid,
	input  wire                 lsu_rready,

	output bus_pkg::addr_t      mem_araddr,
	output logic                mem_arvalid,
	input  wire                 mem_arready,
	input  wire bus_pkg::data_t mem_rdata,
	input  wire bus_pkg::resp_t mem_rresp,
	input  wire                 mem_rvalid,
	output logic                mem_rready,

	axil_read_if.requester      cache_rd,
	axil_write_if.requester     cache_wr,
	axil_read_if.requester      timer_rd
);

	bus_pkg::xbar_state_e state;
	bus_pkg::xbar_state_e state_next;

	bus_pkg::addr_t req_addr;
	bus_pkg::data_t resp_data;
	bus_pkg::resp_t resp_code;

	logic cache_ar_q;
	logic rd_issue_q; // read address pending towards memory or timer.
	logic fill_aw_q;
	logic fill_w_q;

	logic ifu_ar_fire;
	logic lsu_ar_fire;
	logic cache_r_fire;
	logic mem_r_fire;
	logic timer_r_fire;
	logic in_timer;
	logic cache_hit;

	assign ifu_ar_fire  = ifu_arvalid & ifu_arready;
	assign lsu_ar_fire  = lsu_arvalid & lsu_arready;
	assign cache_r_fire = cache_rd.rvalid & cache_rd.rready;
	assign mem_r_fire   = mem_rvalid & mem_rready;
	assign timer_r_fire = timer_rd.rvalid & timer_rd.rready;
	assign cache_hit    = cache_rd.rresp != bus_pkg::resp_decerr;
	assign in_timer     = (req_addr >= bus_pkg::timer_base) && (req_addr <= bus_pkg::timer_last);

	// --------------------------------------------------
	// state machine
	always_comb begin
		state_next = state;
		case (state)
			bus_pkg::idle: begin
				if (ifu_ar_fire)
					state_next = bus_pkg::fetch_lookup;
				else if (lsu_ar_fire)
					state_next = bus_pkg::load_read;
			end
			bus_pkg::fetch_lookup: begin
				if (cache_r_fire)
					state_next = cache_hit ? bus_pkg::fetch_reply : bus_pkg::fetch_memory;
			end
			bus_pkg::fetch_memory: begin
				if (mem_r_fire) begin
					if (mem_rresp == bus_pkg::resp_okay)
						state_next = bus_pkg::fetch_fill;
					else
						state_next = bus_pkg::fetch_reply; // errors are not cached.
				end
			end
			bus_pkg::fetch_fill: begin
				if (cache_wr.bvalid & cache_wr.bready)
					state_next = bus_pkg::fetch_reply;
			end
			bus_pkg::fetch_reply: begin
				if (ifu_rvalid & ifu_rready)
					state_next = bus_pkg::idle;
			end
			bus_pkg::load_read: begin
				if (mem_r_fire | timer_r_fire)
					state_next = bus_pkg::load_reply;
			end
			bus_pkg::load_reply: begin
				if (lsu_rvalid & lsu_rready)
					state_next = bus_pkg::idle;
			end
			default: state_next = bus_pkg::idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= bus_pkg::idle;
			ifu_arready <= 1'b0;
			lsu_arready <= 1'b0;
			cache_ar_q  <= 1'b0;
			rd_issue_q  <= 1'b0;
			fill_aw_q   <= 1'b0;
			fill_w_q    <= 1'b0;
			ifu_rvalid  <= 1'b0;
			lsu_rvalid  <= 1'b0;
		end else begin
			state <= state_next;

			// fetch wins when both requesters are waiting.
			ifu_arready <= (state == bus_pkg::idle) & ifu_arvalid & ~ifu_arready & ~lsu_arready;
			lsu_arready <= (state == bus_pkg::idle) & lsu_arvalid & ~ifu_arvalid & ~lsu_arready;

			if (ifu_ar_fire)
				cache_ar_q <= 1'b1;
			else if (cache_rd.arready)
				cache_ar_q <= 1'b0;

			if (((state == bus_pkg::fetch_lookup) & cache_r_fire & ~cache_hit) | lsu_ar_fire)
				rd_issue_q <= 1'b1;
			else if ((mem_arvalid & mem_arready) | (timer_rd.arvalid & timer_rd.arready))
				rd_issue_q <= 1'b0;

			if ((state == bus_pkg::fetch_memory) & mem_r_fire &
			    (mem_rresp == bus_pkg::resp_okay)) begin
				fill_aw_q <= 1'b1;
				fill_w_q  <= 1'b1;
			end else begin
				if (cache_wr.awready)
					fill_aw_q <= 1'b0;
				if (cache_wr.wready)
					fill_w_q <= 1'b0;
			end

			// valid rises the cycle after the reply state is entered.
			if (ifu_rvalid)
				ifu_rvalid <= ~ifu_rready;
			else
				ifu_rvalid <= state == bus_pkg::fetch_reply;
			if (lsu_rvalid)
				lsu_rvalid <= ~lsu_rready;
			else
				lsu_rvalid <= state == bus_pkg::load_reply;
		end
	end

	// --------------------------------------------------
	// request address and response capture
	always_ff @(posedge clock) begin
		if (ifu_ar_fire)
			req_addr <= ifu_araddr;
		else if (lsu_ar_fire)
			req_addr <= lsu_araddr;

		if (cache_r_fire) begin
			resp_data <= cache_rd.rdata;
			resp_code <= cache_rd.rresp;
		end else if (mem_r_fire) begin
			resp_data <= mem_rdata;
			resp_code <= mem_rresp;
		end else if (timer_r_fire) begin
			resp_data <= timer_rd.rdata;
			resp_code <= timer_rd.rresp;
		end
	end

	// --------------------------------------------------
	// channel outputs
	assign mem_araddr  = req_addr;
	assign mem_arvalid = rd_issue_q & ((state == bus_pkg::fetch_memory) |
	                                   ((state == bus_pkg::load_read) & ~in_timer));
	assign mem_rready  = (state == bus_pkg::fetch_memory) |
	                     ((state == bus_pkg::load_read) & ~in_timer);

	assign timer_rd.araddr  = req_addr;
	assign timer_rd.arvalid = rd_issue_q & (state == bus_pkg::load_read) & in_timer;
	assign timer_rd.rready  = (state == bus_pkg::load_read) & in_timer;

	assign cache_rd.araddr  = req_addr;
	assign cache_rd.arvalid = cache_ar_q;
	assign cache_rd.rready  = state == bus_pkg::fetch_lookup;

	assign cache_wr.awaddr  = req_addr;
	assign cache_wr.awvalid = fill_aw_q;
	assign cache_wr.wdata   = resp_data; // memory word held since fetch_memory.
	assign cache_wr.wvalid  = fill_w_q;
	assign cache_wr.bready  = state == bus_pkg::fetch_fill;

	assign ifu_rdata = resp_data;
	assign ifu_rresp = resp_code;
	assign lsu_rdata = resp_data;
	assign lsu_rresp = resp_code;

endmodule

`default_nettype wire

/* src/fetch_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_cache #(
	parameter int cache_index_bits = 4
) (
	input wire              clock,
	input wire              reset,
	axil_read_if.responder  rd,
	axil_write_if.responder wr
);

	localparam int lines    = 1 << cache_index_bits;
	localparam int tag_bits = 30 - cache_index_bits;

	typedef logic [cache_index_bits-1:0] index_t;
	typedef logic [tag_bits-1:0]         tag_t;

	bus_pkg::data_t   data_mem [lines];
	tag_t             tag_mem [lines];
	logic [lines-1:0] valid_bits;

	index_t rd_index;
	index_t wr_index;
	tag_t   rd_tag;
	tag_t   wr_tag;
	logic   rd_fire;
	logic   wr_fire;

	// word address split: tag above the index, byte offset dropped.
	assign rd_index = rd.araddr[cache_index_bits+1:2];
	assign rd_tag   = rd.araddr[31:cache_index_bits+2];
	assign wr_index = wr.awaddr[cache_index_bits+1:2];
	assign wr_tag   = wr.awaddr[31:cache_index_bits+2];

	// --------------------------------------------------
	// handshakes
	assign rd.arready = ~rd.rvalid;        // one lookup outstanding.
	assign rd_fire    = rd.arvalid & rd.arready;
	assign wr_fire    = wr.awvalid & wr.wvalid & ~wr.bvalid;
	assign wr.awready = wr_fire;           // address and data taken together.
	assign wr.wready  = wr_fire;
	assign wr.bresp   = bus_pkg::resp_okay;

	always_ff @(posedge clock) begin
		if (reset) begin
			rd.rvalid  <= 1'b0;
			wr.bvalid  <= 1'b0;
			valid_bits <= '0;
		end else begin
			if (rd_fire)
				rd.rvalid <= 1'b1;
			else if (rd.rready)
				rd.rvalid <= 1'b0;
			if (wr_fire) begin
				wr.bvalid            <= 1'b1;
				valid_bits[wr_index] <= 1'b1;
			end else if (wr.bready) begin
				wr.bvalid <= 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// line store and lookup
	always_ff @(posedge clock) begin
		if (wr_fire) begin
			data_mem[wr_index] <= wr.wdata;
			tag_mem[wr_index]  <= wr_tag;
		end
		if (rd_fire) begin
			if (valid_bits[rd_index] && tag_mem[rd_index] == rd_tag) begin
				rd.rdata <= data_mem[rd_index];
				rd.rresp <= bus_pkg::resp_okay;
			end else begin
				rd.rdata <= '0;
				rd.rresp <= bus_pkg::resp_decerr; // miss.
			end
		end
	end

endmodule

`default_nettype wire

/* src/fetch_load_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_load_top #(
	parameter int cache_index_bits = 4
) (
	input  wire                 clock,
	input  wire                 reset,

	input  wire bus_pkg::addr_t ifu_araddr,
	input  wire                 ifu_arvalid,
	output logic                ifu_arready,
	output bus_pkg::data_t      ifu_rdata,
	output bus_pkg::resp_t      ifu_rresp,
	output logic                ifu_rvalid,
	input  wire                 ifu_rready,

	input  wire bus_pkg::addr_t lsu_araddr,
	input  wire                 lsu_arvalid,
	output logic                lsu_arready,
	output bus_pkg::data_t      lsu_rdata,
	output bus_pkg::resp_t      lsu_rresp,
	output logic                lsu_rvalid,
	input  wire                 lsu_rready,

	output bus_pkg::addr_t      mem_araddr,
	output logic                mem_arvalid,
	input  wire                 mem_arready,
	input  wire bus_pkg::data_t mem_rdata,
	input  wire bus_pkg::resp_t mem_rresp,
	input  wire                 mem_rvalid,
	output logic                mem_rready
);

	axil_read_if  cache_rd ();
	axil_write_if cache_wr ();
	axil_read_if  timer_rd ();

	// port names match the top level and the channel instances.
	bus_xbar xbar0 (.*);

	fetch_cache #(
		.cache_index_bits(cache_index_bits)
	) icache0 (
		.clock(clock),
		.reset(reset),
		.rd(cache_rd),
		.wr(cache_wr)
	);

	timer_clint clint0 (
		.clock(clock),
		.reset(reset),
		.rd(timer_rd)
	);

endmodule

`default_nettype wire

/* src/timer_clint.sv */
`timescale 1ns/10ps
`default_nettype none

module timer_clint (
	input wire             clock,
	input wire             reset,
	axil_read_if.responder rd
);

	bus_pkg::data_t count;
	logic           rd_fire;

	assign rd.arready = ~rd.rvalid;
	assign rd_fire    = rd.arvalid & rd.arready;

	always_ff @(posedge clock) begin
		if (reset) begin
			count     <= '0;
			rd.rvalid <= 1'b0;
		end else begin
			count <= count + 1'b1; // free running mtime.
			if (rd_fire)
				rd.rvalid <= 1'b1;
			else if (rd.rready)
				rd.rvalid <= 1'b0;
		end
	end

	// only the base word is mapped, the rest of the window errors.
	always_ff @(posedge clock) begin
		if (rd_fire) begin
			if (rd.araddr == bus_pkg::timer_base) begin
				rd.rdata <= count;
				rd.rresp <= bus_pkg::resp_okay;
			end else begin
				rd.rdata <= '0;
				rd.rresp <= bus_pkg::resp_slverr;
			end
		end
	end

endmodule

`default_nettype wire
